// File: verilog/eval_pkg.sv
/* Board evaluator shared definitions
   Piece codes, material tables, score and phase widths, pipeline constants */
`default_nettype none

package eval_pkg;

   localparam int RANKS = 8;                 // Ranks per board
   localparam int FILES = 8;                 // Squares per rank
   localparam int PHASE_SPAN = 62;           // Full-midgame phase weight
   localparam int RECIP_SCALE_LOG2 = 20;     // Fixed point of the reciprocal
   localparam int RECIP_62 = 16912;          // 2^20 / 62, rounded down
   localparam int TAPER_STAGES = 5;          // Registers after the rank units
   localparam int LATENCY = 7;               // Intake + rank + taper

   // Piece type in the low three bits, colour on top
   localparam int BLACK_BIT = 3;
   localparam logic [2:0] PIECE_PAWN = 3'd1;
   localparam logic [2:0] PIECE_KNIGHT = 3'd2;
   localparam logic [2:0] PIECE_BISHOP = 3'd3;
   localparam logic [2:0] PIECE_ROOK = 3'd4;
   localparam logic [2:0] PIECE_QUEEN = 3'd5;
   localparam logic [2:0] PIECE_KING = 3'd6;

   typedef logic [3:0] piece_t;              // One square
   typedef piece_t [FILES-1:0] rank_t;       // File 0 in the low nibble
   typedef rank_t [RANKS-1:0] board_t;       // Square = rank * 8 + file
   typedef logic signed [15:0] score_t;      // White positive
   typedef logic [5:0] phase_t;              // Non-pawn piece count
   typedef logic signed [47:0] wide_t;       // Blend and reciprocal products

   typedef struct packed {
      score_t mg;
      score_t eg;
      phase_t phase;
   } rank_score_t;

   typedef struct packed {
      board_t board;
      logic   black_to_move;
   } eval_req_t;

   // Indexed by piece type; empty and code 7 weigh nothing, nor does the king
   localparam score_t MG_VALUE [8] = '{16'sd0, 16'sd82, 16'sd337, 16'sd365,
                                      16'sd477, 16'sd1025, 16'sd0, 16'sd0};
   localparam score_t EG_VALUE [8] = '{16'sd0, 16'sd94, 16'sd281, 16'sd297,
                                      16'sd512, 16'sd936, 16'sd0, 16'sd0};

endpackage

`default_nettype wire

// File: verilog/board_intake.sv
/* Board intake
   Valid/ready capture of the board and side to move at the pipeline head */
`timescale 1ns/1ns
`default_nettype none

module board_intake
   import eval_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      reset,
   input  wire logic      board_valid,   // Request offered
   input  wire eval_req_t board_req,
   output logic           board_ready,   // Pipeline can move
   input  wire logic      advance,       // From the taper output stage
   output rank_t          ranks [RANKS], // To the rank units
   output logic           black_to_move,
   output logic           stage_valid    // Intake register holds a board
);

   eval_req_t req_q;                     // Captured request

   assign board_ready = advance;         // Accept whenever nothing stalls

   always_ff @(posedge clk)
   begin
      if (reset)
         stage_valid <= 1'b0;
      else if (advance)
         stage_valid <= board_valid;     // Bubble when nothing offered
   end

   always_ff @(posedge clk)
   begin
      if (advance && board_valid)
         req_q <= board_req;             // Capture on transfer
   end

   always_comb
   begin
      for (int r = 0; r < RANKS; r++)
         ranks[r] = req_q.board[r];      // Split into rank slices
   end

   assign black_to_move = req_q.black_to_move;

   // A refused request must be offered again unchanged
   held_req_stable: assert property (@(posedge clk) disable iff (reset)
      board_valid && !board_ready |=> board_valid && $stable(board_req));

endmodule

`default_nettype wire

// File: verilog/rank_material.sv
/* Rank material unit
   Midgame/endgame material and phase count of one rank, one register stage */
`timescale 1ns/1ns
`default_nettype none

module rank_material
   import eval_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  reset,
   input  wire logic  advance,   // Stage enable
   input  wire rank_t rank,      // Eight squares
   output rank_score_t score     // Registered contribution
);

   score_t mg_sum;               // Signed midgame material
   score_t eg_sum;               // Signed endgame material
   phase_t piece_cnt;            // Knights through kings

   always_comb
   begin
      mg_sum = '0;
      eg_sum = '0;
      piece_cnt = '0;
      for (int f = 0; f < FILES; f++)
      begin
         if (rank[f][BLACK_BIT])
         begin
            mg_sum = mg_sum - MG_VALUE[rank[f][2:0]];   // Black counts against
            eg_sum = eg_sum - EG_VALUE[rank[f][2:0]];
         end
         else
         begin
            mg_sum = mg_sum + MG_VALUE[rank[f][2:0]];
            eg_sum = eg_sum + EG_VALUE[rank[f][2:0]];
         end
         // Pawns, empty squares and code 7 leave phase alone
         if (rank[f][2:0] inside {PIECE_KNIGHT, PIECE_BISHOP, PIECE_ROOK,
                                  PIECE_QUEEN, PIECE_KING})
            piece_cnt = piece_cnt + phase_t'(1);
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         score <= '0;
      else if (advance)          // Frozen during a stall
      begin
         score.mg <= mg_sum;
         score.eg <= eg_sum;
         score.phase <= piece_cnt;
      end
   end

endmodule

`default_nettype wire

// File: verilog/taper_pipeline.sv
/* Taper pipeline
   Rank sums, phase blend, reciprocal divide by 62, side sign and output stall */
`timescale 1ns/1ns
`default_nettype none

module taper_pipeline
   import eval_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        reset,
   input  wire rank_score_t rank_scores [RANKS], // From the rank units
   input  wire logic        stage_valid,         // Intake register valid
   input  wire logic        black_to_move,       // Side of the intake board
   output logic             advance,             // Global stage enable
   input  wire logic        eval_ready,
   output logic             eval_valid,
   output score_t           eval
);

   localparam int PAIRS = RANKS / 2;

   // Index 0 sits beside the rank unit registers, k beside taper stage k
   logic [TAPER_STAGES:0]   valid_q;
   logic [TAPER_STAGES-1:0] black_q;             // Side to move per stage

   rank_score_t pair_q [PAIRS];                  // Stage 1, adjacent ranks
   score_t      sum_mg;                          // Adder tree tail
   score_t      sum_eg;
   phase_t      sum_phase;
   score_t      mg_q;                            // Stage 2, board totals
   score_t      eg_q;
   phase_t      phase_q;
   wide_t       mg_term_q;                       // Stage 3, weighted halves
   wide_t       eg_term_q;
   wide_t       scaled_q;                        // Stage 4, times 2^20/62
   wide_t       bias;                            // Round toward zero
   wide_t       quot;                            // Stage 5 input

   assign advance = !(eval_valid && !eval_ready);  // Only stall point
   assign eval_valid = valid_q[TAPER_STAGES];

   always_ff @(posedge clk)
   begin
      if (reset)
         valid_q <= '0;
      else if (advance)
         valid_q <= {valid_q[TAPER_STAGES-1:0], stage_valid};
   end

   always_ff @(posedge clk)
   begin
      if (advance)
         black_q <= {black_q[TAPER_STAGES-2:0], black_to_move};
   end

   always_comb
   begin
      sum_mg = '0;
      sum_eg = '0;
      sum_phase = '0;
      for (int p = 0; p < PAIRS; p++)
      begin
         sum_mg = sum_mg + pair_q[p].mg;
         sum_eg = sum_eg + pair_q[p].eg;
         sum_phase = sum_phase + pair_q[p].phase;
      end
   end

   // Negative products get 2^20 - 1 added so the shift truncates toward zero
   assign bias = (scaled_q < 0) ? (wide_t'(1) <<< RECIP_SCALE_LOG2) - wide_t'(1) : '0;
   assign quot = (scaled_q + bias) >>> RECIP_SCALE_LOG2;

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         for (int p = 0; p < PAIRS; p++)
         begin
            pair_q[p].mg <= rank_scores[2*p].mg + rank_scores[2*p+1].mg;
            pair_q[p].eg <= rank_scores[2*p].eg + rank_scores[2*p+1].eg;
            pair_q[p].phase <= rank_scores[2*p].phase + rank_scores[2*p+1].phase;
         end
         mg_q <= sum_mg;
         eg_q <= sum_eg;
         phase_q <= sum_phase;
         mg_term_q <= wide_t'(mg_q) * wide_t'(phase_q);              // Midgame weight
         eg_term_q <= wide_t'(eg_q) * (wide_t'(PHASE_SPAN) - wide_t'(phase_q));
         scaled_q <= (mg_term_q + eg_term_q) * wide_t'(RECIP_62);
         if (black_q[TAPER_STAGES-1])
            eval <= -score_t'(quot);                                 // Black's view
         else
            eval <= score_t'(quot);
      end
   end

   // Held result may not change until taken
   eval_hold: assert property (@(posedge clk) disable iff (reset)
      eval_valid && !eval_ready |=> eval_valid && $stable(eval));

   // Endgame weight stays non-negative now that phase is not clamped
   phase_in_span: assert property (@(posedge clk) disable iff (reset)
      valid_q[2] |-> phase_q <= phase_t'(PHASE_SPAN));

endmodule

`default_nettype wire

// File: verilog/eval_top.sv
/* Board evaluator top
   Intake stage, eight rank material units and the taper pipeline */
`timescale 1ns/1ns
`default_nettype none

module eval_top
   import eval_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      reset,
   input  wire logic      board_valid,
   input  wire eval_req_t board_req,   // Board plus side to move
   output logic           board_ready,
   output logic           eval_valid,
   output score_t         eval,        // Side-to-move relative score
   input  wire logic      eval_ready
);

   logic        advance;               // Shared stage enable
   logic        stage_valid;           // Intake register valid
   logic        black_to_move;         // Registered side
   rank_t       ranks [RANKS];         // Intake to rank units
   rank_score_t rank_scores [RANKS];   // Rank units to taper

   board_intake u_intake (
      .clk           (clk),
      .reset         (reset),
      .board_valid   (board_valid),
      .board_req     (board_req),
      .board_ready   (board_ready),
      .advance       (advance),
      .ranks         (ranks),
      .black_to_move (black_to_move),
      .stage_valid   (stage_valid)
   );

   for (genvar g = 0; g < RANKS; g++)
   begin : g_rank
      rank_material u_rank (
         .clk     (clk),
         .reset   (reset),
         .advance (advance),
         .rank    (ranks[g]),
         .score   (rank_scores[g])
      );
   end

   taper_pipeline u_taper (
      .clk           (clk),
      .reset         (reset),
      .rank_scores   (rank_scores),
      .stage_valid   (stage_valid),
      .black_to_move (black_to_move),
      .advance       (advance),
      .eval_ready    (eval_ready),
      .eval_valid    (eval_valid),
      .eval          (eval)
   );

endmodule

`default_nettype wire

// File: tb/eval_model.svh
/* Board evaluator scoring model
   Material values, phase count, tapered reciprocal blend and random boards */
`ifndef EVAL_MODEL_SVH
`define EVAL_MODEL_SVH

// Material of one piece type, midgame or endgame table
function automatic int piece_worth(input logic [2:0] kind, input bit endgame);
   case (kind)
      3'd1: return endgame ? 94 : 82;        // Pawn
      3'd2: return endgame ? 281 : 337;      // Knight
      3'd3: return endgame ? 297 : 365;      // Bishop
      3'd4: return endgame ? 512 : 477;      // Rook
      3'd5: return endgame ? 936 : 1025;     // Queen
      default: return 0;                     // Empty, king, unused code
   endcase
endfunction

// Blend over a 62 phase span, then times 2^20/62 and back down by 2^20
function automatic int taper_blend(input int mg, input int eg, input int phase);
   longint blend;
   blend = longint'(mg) * phase + longint'(eg) * (62 - phase);
   return int'((blend * 16912) / 1048576);   // Integer divide truncates toward zero
endfunction

function automatic score_t expected_eval(input eval_req_t req);
   int     mg;
   int     eg;
   int     phase;
   int     value;
   piece_t sq;
   mg = 0;
   eg = 0;
   phase = 0;
   for (int r = 0; r < 8; r++)
      for (int f = 0; f < 8; f++)
      begin
         sq = req.board[r][f];
         mg += sq[3] ? -piece_worth(sq[2:0], 0) : piece_worth(sq[2:0], 0);
         eg += sq[3] ? -piece_worth(sq[2:0], 1) : piece_worth(sq[2:0], 1);
         if (sq[2:0] >= 3'd2 && sq[2:0] <= 3'd6)
            phase++;                         // Knight up to king
      end
   value = taper_blend(mg, eg, phase);
   if (req.black_to_move)
      value = -value;                        // Side to move view
   return score_t'(value);
endfunction

// Half the squares empty, the rest any colour and type 1 to 7
function automatic eval_req_t random_board();
   eval_req_t  req;
   logic [2:0] kind;
   logic       side;
   req = '0;
   for (int r = 0; r < 8; r++)
      for (int f = 0; f < 8; f++)
         if ($urandom_range(1, 0) == 1)
         begin
            kind = 3'($urandom_range(7, 1));
            side = 1'($urandom_range(1, 0));
            req.board[r][f] = {side, kind};
         end
   req.black_to_move = 1'($urandom_range(1, 0));
   return req;
endfunction

`endif

// File: tb/eval_tb.sv
/* Board evaluator testbench
   Random boards under back-pressure, checked against a scoring model */
`timescale 1ns/1ns
`default_nettype none

module eval_tb
   import eval_pkg::*;
();

   `include "eval_model.svh"

   localparam int WAIT_LIMIT = 200;      // Cycles allowed for one wait

   logic      clk;
   logic      reset;
   logic      board_valid;
   eval_req_t board_req;
   logic      board_ready;
   logic      eval_valid;
   score_t    eval;
   logic      eval_ready;

   score_t    expected_q [$];            // Model results in acceptance order
   eval_req_t offer_req;                 // Board currently on the bus
   logic      pending;                   // Offer not yet taken
   logic      held;                      // Result stalled last cycle
   score_t    held_eval;
   int        accepted;
   int        seed_dummy;

   always #5 clk = ~clk;

   eval_top dut (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_req   (board_req),
      .board_ready (board_ready),
      .eval_valid  (eval_valid),
      .eval        (eval),
      .eval_ready  (eval_ready)
   );

   task automatic check_value(input string what, input int got, input int expected);
      if (got != expected)
      begin
         $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
         $display("Some tests failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic give_up(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "run aborted");
   endtask

   // One clock of traffic, inputs 1 ns after the edge, outputs read at 3 ns
   task automatic traffic_cycle(input bit may_offer, input int offer_pct, input int ready_pct);
      @(posedge clk);
      #1;
      if (!pending && may_offer && $urandom_range(99, 0) < offer_pct)
      begin
         offer_req = random_board();
         pending = 1'b1;
      end
      board_valid = pending;             // Refused offer stays as it was
      board_req = offer_req;
      eval_ready = ($urandom_range(99, 0) < ready_pct);
      #2;
      if (held)
      begin
         check_value("eval_valid while stalled", int'(eval_valid), 1);
         check_value("eval while stalled", int'(eval), int'(held_eval));
      end
      held = eval_valid && !eval_ready;
      held_eval = eval;
      if (eval_valid && eval_ready)
      begin
         if (expected_q.size() == 0)
            give_up("A result arrived with no board outstanding");
         else
            check_value("eval", int'(eval), int'(expected_q.pop_front()));
      end
      if (board_valid && board_ready)
      begin
         expected_q.push_back(expected_eval(offer_req));
         pending = 1'b0;
         accepted++;
      end
   endtask

   task automatic run_stream(input int count, input int offer_pct, input int ready_pct);
      int cycles;
      cycles = 0;
      accepted = 0;
      held = 1'b0;
      while (accepted < count)
      begin
         if (cycles > count * 20)
            give_up("Boards were not accepted in time");
         else
         begin
            traffic_cycle(1'b1, offer_pct, ready_pct);
            if (ready_pct == 100)
               check_value("board_ready without back-pressure", int'(board_ready), 1);
            cycles++;
         end
      end
      cycles = 0;
      while (expected_q.size() != 0)
      begin
         if (cycles >= WAIT_LIMIT)
            give_up("Results stopped arriving before every board came back");
         else
         begin
            traffic_cycle(1'b0, 0, 100);
            cycles++;
         end
      end
      repeat (LATENCY + 1)
         traffic_cycle(1'b0, 0, 100);    // Catches a duplicated result
   endtask

   // Single board into an empty pipeline, latency counted from the offer
   task automatic send_alone(input eval_req_t req, output score_t result);
      int cycles;
      @(posedge clk);
      #1;
      board_valid = 1'b1;
      board_req = req;
      eval_ready = 1'b1;
      #2;
      check_value("board_ready with an empty pipeline", int'(board_ready), 1);
      @(posedge clk);                    // Accepting edge
      #1;
      board_valid = 1'b0;
      cycles = 1;
      while (!eval_valid)
      begin
         if (cycles >= WAIT_LIMIT)
            give_up("No result came back for a single board");
         else
         begin
            @(posedge clk);
            #1;
            cycles++;
         end
      end
      check_value("cycles from offer to eval_valid", cycles, LATENCY);
      check_value("single board eval", int'(eval), int'(expected_eval(req)));
      result = eval;
      @(posedge clk);                    // Result taken here
      #1;
      check_value("eval_valid after the result was taken", int'(eval_valid), 0);
   endtask

   initial
   begin
      eval_req_t board;
      eval_req_t kings;
      score_t    white_score;
      score_t    black_score;
      seed_dummy = $urandom(33);
      clk = 1'b0;
      reset = 1'b1;
      board_valid = 1'b0;
      board_req = '0;
      eval_ready = 1'b0;
      offer_req = '0;
      pending = 1'b0;
      held = 1'b0;
      held_eval = '0;
      accepted = 0;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      eval_ready = 1'b1;
      #2;
      check_value("eval_valid after reset", int'(eval_valid), 0);
      check_value("board_ready after reset", int'(board_ready), 1);

      run_stream(300, 100, 100);         // Back-to-back, no stalls

      board = random_board();
      board.black_to_move = 1'b0;
      send_alone(board, white_score);
      board.black_to_move = 1'b1;
      send_alone(board, black_score);
      check_value("black to move score", int'(black_score), -int'(white_score));

      run_stream(300, 70, 60);           // Random offers, ready low 40%

      kings = '0;
      kings.board[0][4] = 4'h6;          // White king e1
      kings.board[7][4] = 4'hE;          // Black king e8
      send_alone(kings, white_score);
      check_value("kings only", int'(white_score), 0);
      kings.board[0][3] = 4'h5;          // White queen d1, phase 3
      send_alone(kings, white_score);
      check_value("king and queen against king", int'(white_score), 940);

      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
+incdir+tb
verilog/eval_pkg.sv
verilog/board_intake.sv
verilog/rank_material.sv
verilog/taper_pipeline.sv
verilog/eval_top.sv
tb/eval_tb.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the board evaluator testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module eval_tb -o eval_sim -f list.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed"
   exit "$status"
fi

./obj_dir/eval_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation ended with a failure"
   exit "$status"
fi

exit 0
